//--- rtl/pianoTiles_params.svh
`ifndef PIANOTILES_PARAMS_SVH
`define PIANOTILES_PARAMS_SVH

// Playfield geometry in pixel rows
`define SCREEN_HEIGHT 120
`define TILE_HEIGHT 20

// Lanes on screen and tiles that can fall at once
`define LANES 4
`define SLOTS 4

// Clock cycles per one-row fall step
`define STEP_CYCLES 8

// Clock cycles between spawn attempts
`define SPAWN_CYCLES 300

// Nonzero start value for the lane LFSR
`define LFSR_SEED 24'h800001

// Score counter width, wraps at the top
`define SCORE_WIDTH 8

`endif

//--- rtl/pianoTilesPkg.sv
package pianoTilesPkg;

	// One bit per lane, bit 0 is the leftmost lane
	typedef logic [3:0] laneMaskT;

	// One falling tile
	typedef struct packed
	{
		logic       active;
		logic [1:0] lane;
		// Row of the tile, 0 at the top
		logic [6:0] y;
		// Set once the tile has been hit
		logic       scored;
	} tileSlotT;

	// Result of one cycle of play in the field
	typedef struct packed
	{
		// New hits this cycle, 0 to 4
		logic [2:0] hits;
		logic       miss;
	} fieldEventT;

endpackage

//--- rtl/keyPress.sv
`timescale 1ns/1ps

module keyPress
	import pianoTilesPkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  logic [3:0] KEY,
	output laneMaskT   press
);

	// Keys are active low and numbered right to left
	logic [3:0] pressedNow;
	logic [3:0] prevPressed;

	assign pressedNow = ~{KEY[0], KEY[1], KEY[2], KEY[3]};

	// Pulse on the first sample of a new push
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			prevPressed <= '1;
			press <= '0;
		end
		else
		begin
			prevPressed <= pressedNow;
			press <= pressedNow & ~prevPressed;
		end
	end

endmodule

//--- rtl/tileField.sv
`timescale 1ns/1ps
`include "pianoTiles_params.svh"

module tileField
	import pianoTilesPkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  logic       hold,
	input  logic       restart,
	input  laneMaskT   playPress,
	output fieldEventT fieldEvent
);

	localparam int STEP_W = $clog2(`STEP_CYCLES + 1);
	localparam int SPAWN_W = $clog2(`SPAWN_CYCLES + 1);
	// Hit window is every row below this one
	localparam logic [6:0] WINDOW_TOP = 7'(`SCREEN_HEIGHT - `TILE_HEIGHT);
	localparam logic [6:0] BOTTOM_ROW = 7'(`SCREEN_HEIGHT - 1);

	tileSlotT slots [`SLOTS];
	tileSlotT nextSlots [`SLOTS];

	logic [STEP_W-1:0] stepCount;
	logic [SPAWN_W-1:0] spawnCount;
	logic stepDone;
	logic spawnDone;

	logic [23:0] lfsr;

	logic [`SLOTS-1:0] inWindow;
	logic [`SLOTS-1:0] hitMask;
	logic [2:0] hitCount;
	logic missPress;
	logic exitMiss;

	assign stepDone = (stepCount == STEP_W'(`STEP_CYCLES - 1));
	assign spawnDone = (spawnCount == SPAWN_W'(`SPAWN_CYCLES - 1));

	always_comb
	begin
		for (int s = 0; s < `SLOTS; s++)
		begin
			inWindow[s] = slots[s].active && (slots[s].y > WINDOW_TOP);
		end
	end

	// Each press claims the lowest slot of its lane inside the window
	always_comb
	begin : hitMatch
		logic found;
		hitMask = '0;
		missPress = 1'b0;
		for (int l = 0; l < `LANES; l++)
		begin
			found = 1'b0;
			for (int s = 0; s < `SLOTS; s++)
			begin
				if (!found && inWindow[s] && (slots[s].lane == 2'(l)))
				begin
					found = 1'b1;
					hitMask[s] = playPress[l];
				end
			end
			if (playPress[l] && !found)
			begin
				missPress = 1'b1;
			end
		end
	end

	// Repeat hits on a scored tile count nothing
	always_comb
	begin
		hitCount = '0;
		for (int s = 0; s < `SLOTS; s++)
		begin
			if (hitMask[s] && !slots[s].scored)
			begin
				hitCount = hitCount + 3'd1;
			end
		end
	end

	always_comb
	begin : slotUpdate
		logic freeFound;
		nextSlots = slots;
		exitMiss = 1'b0;
		freeFound = 1'b0;
		for (int s = 0; s < `SLOTS; s++)
		begin
			if (hitMask[s])
			begin
				nextSlots[s].scored = 1'b1;
			end
			if (stepDone && slots[s].active)
			begin
				if (slots[s].y == BOTTOM_ROW)
				begin
					nextSlots[s].active = 1'b0;
					// Leaving the screen unhit ends the game
					if (!slots[s].scored && !hitMask[s])
					begin
						exitMiss = 1'b1;
					end
				end
				else
				begin
					nextSlots[s].y = slots[s].y + 7'd1;
				end
			end
			// New tile takes the first slot that was free
			if (spawnDone && !freeFound && !slots[s].active)
			begin
				nextSlots[s] = '{active: 1'b1, lane: lfsr[1:0], y: '0, scored: 1'b0};
				freeFound = 1'b1;
			end
		end
	end

	// Lane source keeps running through hold and restart
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			lfsr <= `LFSR_SEED;
		end
		else
		begin
			lfsr <= {lfsr[22:0], lfsr[23] ^ lfsr[22] ^ lfsr[17] ^ lfsr[16]};
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (rst || restart)
		begin
			slots <= '{default: '0};
			stepCount <= '0;
			spawnCount <= '0;
			fieldEvent <= '0;
		end
		else if (hold)
		begin
			fieldEvent <= '0;
		end
		else
		begin
			slots <= nextSlots;
			stepCount <= stepDone ? '0 : stepCount + 1'b1;
			spawnCount <= spawnDone ? '0 : spawnCount + 1'b1;
			fieldEvent <= '{hits: hitCount, miss: missPress || exitMiss};
		end
	end

endmodule

//--- rtl/gameControl.sv
`timescale 1ns/1ps
`include "pianoTiles_params.svh"

module gameControl
	import pianoTilesPkg::*;
(
	input  logic                    CLOCK_50,
	input  logic                    rst,
	input  laneMaskT                press,
	input  fieldEventT              fieldEvent,
	output laneMaskT                playPress,
	output logic                    hold,
	output logic                    restart,
	output logic [`SCORE_WIDTH-1:0] score,
	output logic                    gameOver
);

	// Presses only reach the field during play
	assign playPress = gameOver ? '0 : press;

	// Field freezes while the game is over
	assign hold = gameOver;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			gameOver <= 1'b0;
			score <= '0;
			restart <= 1'b0;
		end
		else
		begin
			restart <= 1'b0;
			if (gameOver)
			begin
				// Any key starts a new game
				if (|press)
				begin
					gameOver <= 1'b0;
					score <= '0;
					restart <= 1'b1;
				end
			end
			else
			begin
				score <= score + `SCORE_WIDTH'(fieldEvent.hits);
				if (fieldEvent.miss)
				begin
					gameOver <= 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/scoreDisplay.sv
`timescale 1ns/1ps

module scoreDisplay
(
	input  logic [7:0] score,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1
);

	logic [4:0] tens;
	logic [3:0] ones;

	// Active-low segments, g down to a
	function automatic logic [6:0] segPattern(input logic [4:0] digit);
		case (digit)
			5'd0: segPattern = 7'h40;
			5'd1: segPattern = 7'h79;
			5'd2: segPattern = 7'h24;
			5'd3: segPattern = 7'h30;
			5'd4: segPattern = 7'h19;
			5'd5: segPattern = 7'h12;
			5'd6: segPattern = 7'h02;
			5'd7: segPattern = 7'h78;
			5'd8: segPattern = 7'h00;
			5'd9: segPattern = 7'h10;
			// Blank, only reached by tens above 9
			default: segPattern = 7'h7F;
		endcase
	endfunction

	assign tens = 5'(score / 8'd10);
	assign ones = 4'(score % 8'd10);

	assign HEX1 = segPattern(tens);
	assign HEX0 = segPattern({1'b0, ones});

endmodule

//--- rtl/pianoTilesTop.sv
`timescale 1ns/1ps

module pianoTilesTop
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  logic [3:0] KEY,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [9:0] LEDR
);

	logic [3:0] press;
	logic [3:0] playPress;
	logic [3:0] fieldEvent;
	logic hold;
	logic restart;
	logic [7:0] score;
	logic gameOver;

	keyPress keys0
	(
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.KEY      (KEY),
		.press    (press)
	);

	tileField field0
	(
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.hold       (hold),
		.restart    (restart),
		.playPress  (playPress),
		.fieldEvent (fieldEvent)
	);

	gameControl control0
	(
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.press      (press),
		.fieldEvent (fieldEvent),
		.playPress  (playPress),
		.hold       (hold),
		.restart    (restart),
		.score      (score),
		.gameOver   (gameOver)
	);

	scoreDisplay display0
	(
		.score (score),
		.HEX0  (HEX0),
		.HEX1  (HEX1)
	);

	// LEDR[8] unused
	assign LEDR = {gameOver, 1'b0, score};

endmodule

//--- verification/tbPianoTiles.sv
`timescale 1ns/1ps
`include "pianoTiles_params.svh"

module tbPianoTiles;

	localparam logic [6:0] WINDOW_ROW = 7'(`SCREEN_HEIGHT - `TILE_HEIGHT);
	localparam logic [6:0] LAST_ROW = 7'(`SCREEN_HEIGHT - 1);

	logic CLOCK_50;
	logic rst;
	logic [3:0] KEY;
	logic [6:0] HEX0;
	logic [6:0] HEX1;
	logic [9:0] LEDR;

	// Stimulus state
	logic [15:0] rngState;
	bit pushReq;
	int pushLane;
	int lowLeft;
	int highLeft;

	// Game model
	logic [3:0] mPrev;
	logic [3:0] mPress;
	logic [`SLOTS-1:0] mActive;
	logic [`SLOTS-1:0] mScored;
	logic [1:0] mLane [`SLOTS];
	logic [6:0] mY [`SLOTS];
	int mStep;
	int mSpawn;
	logic [23:0] mLfsr;
	logic [2:0] mHits;
	logic mMiss;
	logic mGameOver;
	logic mRestart;
	logic [7:0] mScore;
	int mHitTotal;
	int mRepeatTotal;
	int savedHits;
	logic [7:0] savedScore;

	pianoTilesTop dut0
	(
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.KEY      (KEY),
		.HEX0     (HEX0),
		.HEX1     (HEX1),
		.LEDR     (LEDR)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	// Galois LFSR, one step per bit
	function automatic int randBits(input int n);
		randBits = 0;
		for (int i = 0; i < n; i++)
		begin
			rngState = rngState[0] ? ((rngState >> 1) ^ 16'hB400) : (rngState >> 1);
			randBits = (randBits << 1) | int'(rngState[0]);
		end
	endfunction

	function automatic logic [6:0] digitPattern(input int d);
		case (d)
			0: digitPattern = 7'h40;
			1: digitPattern = 7'h79;
			2: digitPattern = 7'h24;
			3: digitPattern = 7'h30;
			4: digitPattern = 7'h19;
			5: digitPattern = 7'h12;
			6: digitPattern = 7'h02;
			7: digitPattern = 7'h78;
			8: digitPattern = 7'h00;
			9: digitPattern = 7'h10;
			default: digitPattern = 7'h7F;
		endcase
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", testName, expected, actual);
			$display("TB FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic failTimeout(input string testName);
		$display("Timed out waiting for the DUT in %s", testName);
		$display("TB FAILED");
		$fatal(1, "Wait limit exceeded");
	endtask

	task automatic modelReset();
		mPrev = 4'hF;
		mPress = '0;
		mActive = '0;
		mScored = '0;
		for (int s = 0; s < `SLOTS; s++)
		begin
			mLane[s] = '0;
			mY[s] = '0;
		end
		mStep = 0;
		mSpawn = 0;
		mLfsr = `LFSR_SEED;
		mHits = '0;
		mMiss = 1'b0;
		mGameOver = 1'b0;
		mRestart = 1'b0;
		mScore = '0;
	endtask

	// One clock edge of the whole game, keys as sampled at that edge
	task automatic modelStep(input logic [3:0] keys);
		logic [3:0] play;
		logic [3:0] nowPressed;
		logic [`SLOTS-1:0] oldActive;
		logic [`SLOTS-1:0] oldScored;
		logic [`SLOTS-1:0] hitSlot;
		logic [1:0] oldLane [`SLOTS];
		logic [6:0] oldY [`SLOTS];
		int newHits;
		logic newMiss;
		logic found;
		logic spawned;
		play = mGameOver ? 4'b0 : mPress;
		newHits = 0;
		newMiss = 1'b0;
		hitSlot = '0;
		oldActive = mActive;
		oldScored = mScored;
		for (int s = 0; s < `SLOTS; s++)
		begin
			oldLane[s] = mLane[s];
			oldY[s] = mY[s];
		end
		if (mRestart)
		begin
			mActive = '0;
			mScored = '0;
			mStep = 0;
			mSpawn = 0;
		end
		else if (!mGameOver)
		begin
			for (int l = 0; l < `LANES; l++)
			begin
				found = 1'b0;
				for (int s = 0; s < `SLOTS; s++)
				begin
					if (play[l] && !found && oldActive[s] && oldLane[s] == 2'(l)
						&& oldY[s] > WINDOW_ROW)
					begin
						found = 1'b1;
						hitSlot[s] = 1'b1;
						mScored[s] = 1'b1;
						if (oldScored[s])
							mRepeatTotal++;
						else
							newHits++;
					end
				end
				if (play[l] && !found)
					newMiss = 1'b1;
			end
			if (mStep == `STEP_CYCLES - 1)
			begin
				mStep = 0;
				for (int s = 0; s < `SLOTS; s++)
				begin
					if (oldActive[s] && oldY[s] == LAST_ROW)
					begin
						mActive[s] = 1'b0;
						newMiss = newMiss | (!oldScored[s] && !hitSlot[s]);
					end
					else if (oldActive[s])
						mY[s] = oldY[s] + 7'd1;
				end
			end
			else
				mStep++;
			if (mSpawn == `SPAWN_CYCLES - 1)
			begin
				mSpawn = 0;
				spawned = 1'b0;
				for (int s = 0; s < `SLOTS; s++)
				begin
					if (!spawned && !oldActive[s])
					begin
						spawned = 1'b1;
						mActive[s] = 1'b1;
						mScored[s] = 1'b0;
						mY[s] = '0;
						mLane[s] = mLfsr[1:0];
					end
				end
			end
			else
				mSpawn++;
		end
		mLfsr = {mLfsr[22:0], mLfsr[23] ^ mLfsr[22] ^ mLfsr[17] ^ mLfsr[16]};
		mRestart = 1'b0;
		if (mGameOver && |mPress)
		begin
			mGameOver = 1'b0;
			mScore = '0;
			mRestart = 1'b1;
		end
		else if (!mGameOver)
		begin
			mScore = mScore + 8'(mHits);
			if (mMiss)
				mGameOver = 1'b1;
		end
		mHits = 3'(newHits);
		mMiss = newMiss;
		mHitTotal += newHits;
		// KEY[3] is lane 0
		nowPressed = ~{keys[0], keys[1], keys[2], keys[3]};
		mPress = nowPressed & ~mPrev;
		mPrev = nowPressed;
	endtask

	function automatic bit keyIdle();
		keyIdle = (lowLeft == 0) && (highLeft == 0) && !pushReq;
	endfunction

	// Also counts the row just above the window, a tile there can enter it before a press lands
	function automatic bit laneInWindow(input int lane);
		laneInWindow = 1'b0;
		for (int s = 0; s < `SLOTS; s++)
			if (mActive[s] && mLane[s] == 2'(lane) && mY[s] >= WINDOW_ROW)
				laneInWindow = 1'b1;
	endfunction

	// Lane of the lowest slot in the window, -1 if none
	function automatic int windowLane();
		windowLane = -1;
		for (int s = `SLOTS - 1; s >= 0; s--)
			if (mActive[s] && mY[s] > WINDOW_ROW)
				windowLane = int'(mLane[s]);
	endfunction

	task automatic requestPush(input int lane);
		pushReq = 1'b1;
		pushLane = lane;
	endtask

	// Two cycles low, then at least two high
	task automatic driveKeys();
		if (lowLeft > 0)
		begin
			lowLeft--;
			if (lowLeft == 0)
			begin
				KEY <= 4'hF;
				highLeft = 2;
			end
		end
		else if (highLeft > 0)
			highLeft--;
		else if (pushReq)
		begin
			KEY <= ~(4'b1000 >> pushLane);
			lowLeft = 2;
			pushReq = 1'b0;
		end
	endtask

	task automatic checkOutputs(input string testName);
		checkValue({testName, " LEDR"}, 32'({mGameOver, 1'b0, mScore}), 32'(LEDR));
		checkValue({testName, " HEX1"}, 32'(digitPattern(int'(mScore) / 10)), 32'(HEX1));
		checkValue({testName, " HEX0"}, 32'(digitPattern(int'(mScore) % 10)), 32'(HEX0));
	endtask

	task automatic runCycle(input string testName);
		@(posedge CLOCK_50);
		modelStep(KEY);
		driveKeys();
		@(negedge CLOCK_50);
		checkOutputs(testName);
	endtask

	task automatic waitKeyIdle(input string testName);
		for (int n = 0; n < 10 && !keyIdle(); n++)
			runCycle(testName);
		if (!keyIdle())
			failTimeout(testName);
	endtask

	task automatic waitGameOver(input string testName, input logic level, input int limit);
		for (int n = 0; n < limit && LEDR[9] !== level; n++)
			runCycle(testName);
		if (LEDR[9] !== level)
			failTimeout(testName);
	endtask

	task automatic restartGame(input string testName);
		waitKeyIdle(testName);
		requestPush(0);
		waitGameOver(testName, 1'b0, 20);
		checkValue({testName, " cleared"}, 32'd0, 32'(LEDR));
	endtask

	task automatic playCycles(input string testName, input int count, input bit allowWrong);
		int r;
		int lane;
		for (int i = 0; i < count; i++)
		begin
			if (keyIdle())
			begin
				r = randBits(9);
				lane = windowLane();
				if (mGameOver && r < 64)
					requestPush(r % 4);
				else if (!mGameOver && lane >= 0 && r < 128)
					requestPush(lane);
				else if (!mGameOver && allowWrong && r == 511)
				begin
					lane = randBits(2);
					requestPush(lane);
				end
			end
			runCycle(testName);
		end
	endtask

	initial
	begin
		int lane;
		CLOCK_50 = 1'b0;
		rst = 1'b1;
		KEY = 4'hF;
		rngState = 16'd86;
		pushReq = 1'b0;
		pushLane = 0;
		lowLeft = 0;
		highLeft = 0;
		mHitTotal = 0;
		mRepeatTotal = 0;
		modelReset();
		repeat (2) @(posedge CLOCK_50);
		rst <= 1'b0;
		@(negedge CLOCK_50);
		checkValue("reset LEDR", 32'd0, 32'(LEDR));
		checkValue("reset HEX1", 32'h40, 32'(HEX1));
		checkValue("reset HEX0", 32'h40, 32'(HEX0));
		checkOutputs("reset");

		playCycles("hits", 4000, 1'b0);
		checkValue("hits seen", 32'd1, 32'(mHitTotal > 0));
		checkValue("repeat hits seen", 32'd1, 32'(mRepeatTotal > 0));

		// Push a lane that has nothing in the window
		if (LEDR[9])
			restartGame("wrong lane restart");
		waitKeyIdle("wrong lane");
		lane = 0;
		for (int l = `LANES - 1; l >= 0; l--)
			if (!laneInWindow(l))
				lane = l;
		requestPush(lane);
		waitGameOver("wrong lane", 1'b1, 20);
		savedScore = mScore;
		repeat (20) runCycle("wrong lane hold");
		checkValue("wrong lane score held", 32'(savedScore), 32'(LEDR[7:0]));

		// Empty field, first tile falls through unhit
		restartGame("unhit restart");
		waitGameOver("unhit", 1'b1, `SPAWN_CYCLES + `SCREEN_HEIGHT * `STEP_CYCLES + 50);

		restartGame("resume restart");
		savedHits = mHitTotal;
		playCycles("resume", 6000, 1'b1);
		checkValue("resume hits seen", 32'd1, 32'(mHitTotal > savedHits));

		$display("TB PASSED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+rtl
rtl/pianoTilesPkg.sv
rtl/keyPress.sv
rtl/tileField.sv
rtl/gameControl.sv
rtl/scoreDisplay.sv
rtl/pianoTilesTop.sv
verification/tbPianoTiles.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run, exit status is the verdict
verilator --binary -f compile.f --top-module tbPianoTiles -Mdir obj_dir \
	&& ./obj_dir/VtbPianoTiles \
	|| exit 1
